// File: Makefile
# Verilator build, run and lint for the flit narrowing testbench
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP        := tb_flit_narrow
FILELIST   := project.f
OBJ_DIR    := obj_dir
PASS_MSG   := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass message shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/flit_narrow_top.sv
// Flit narrowing top level: input FIFO, slice serializer and output skid slice
`default_nettype none

module flit_narrow_top #(
  parameter bit MSB_FIRST  = ser_cfg_pkg::DEFAULT_MSB_FIRST,
  parameter int FIFO_DEPTH = ser_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                         clk,
  input  wire                         rst_n,
  // Wide input stream
  input  wire                         in_valid,
  output logic                        in_ready,
  input  ser_types_pkg::wide_data_t   in_data,
  input  wire                         in_last,
  input  ser_types_pkg::slice_id_t    in_dont_care,
  input  ser_types_pkg::meta_t        in_meta,
  // Narrow output stream
  output logic                        out_valid,
  input  wire                         out_ready,
  output ser_types_pkg::narrow_data_t out_data,
  output logic                        out_last,
  output ser_types_pkg::meta_t        out_meta
);

  import ser_types_pkg::*;

  // ------------------------------
  // FIFO head to serializer
  // ------------------------------
  logic      head_valid;
  logic      head_ready;
  wide_data_t head_data;
  logic      head_last;
  slice_id_t head_dont_care;
  meta_t     head_meta;

  // Serializer to skid slice
  logic         ser_valid;
  logic         ser_ready;
  narrow_data_t ser_data;
  logic         ser_last;
  meta_t        ser_meta;

  // Holds wide flits stable while they are being sliced
  flit_push_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk, .rst_n,
    .in_valid, .in_ready, .in_data, .in_last, .in_dont_care, .in_meta,
    .head_valid, .head_ready, .head_data, .head_last, .head_dont_care, .head_meta
  );

  flit_serializer #(
    .MSB_FIRST (MSB_FIRST)
  ) u_ser (
    .clk, .rst_n,
    .head_valid, .head_ready, .head_data, .head_last, .head_dont_care, .head_meta,
    .ser_valid, .ser_ready, .ser_data, .ser_last, .ser_meta
  );

  // Registers the narrow stream and absorbs back-pressure without bubbles
  pop_skid_slice u_skid (
    .clk, .rst_n,
    .ser_valid, .ser_ready, .ser_data, .ser_last, .ser_meta,
    .out_valid, .out_ready, .out_data, .out_last, .out_meta
  );

endmodule : flit_narrow_top

`default_nettype wire

// File: logic/flit_push_fifo.sv
// Input FIFO for wide flits that keeps the head flit stable until it is popped
`default_nettype none

module flit_push_fifo #(
  parameter int DEPTH = ser_cfg_pkg::DEFAULT_FIFO_DEPTH
) (
  input  wire                       clk,
  input  wire                       rst_n,
  // Wide flit push side
  input  wire                       in_valid,
  output logic                      in_ready,
  input  ser_types_pkg::wide_data_t in_data,
  input  wire                       in_last,
  input  ser_types_pkg::slice_id_t  in_dont_care,
  input  ser_types_pkg::meta_t      in_meta,
  // Head flit towards the serializer
  output logic                      head_valid,
  input  wire                       head_ready,
  output ser_types_pkg::wide_data_t head_data,
  output logic                      head_last,
  output ser_types_pkg::slice_id_t  head_dont_care,
  output ser_types_pkg::meta_t      head_meta
);

  import ser_types_pkg::*;

  // A depth of one still needs a one-bit pointer
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage holds every field of an entry side by side
  wide_data_t mem_data [DEPTH];
  logic       mem_last [DEPTH];
  slice_id_t  mem_dc   [DEPTH];
  meta_t      mem_meta [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Ready looks at fullness only, which keeps the input ready path to one compare
  assign in_ready   = (count != CNT_W'(DEPTH));
  assign head_valid = (count != '0);
  assign push       = in_valid && in_ready;
  assign pop        = head_valid && head_ready;

  // Head comes straight out of storage so it only moves when rd_ptr moves
  assign head_data      = mem_data[rd_ptr];
  assign head_last      = mem_last[rd_ptr];
  assign head_dont_care = mem_dc[rd_ptr];
  assign head_meta      = mem_meta[rd_ptr];

  // ------------------------------
  // Storage write
  // ------------------------------
  always_ff @(posedge clk) begin
    if (push) begin
      mem_data[wr_ptr] <= in_data;
      mem_last[wr_ptr] <= in_last;
      mem_dc[wr_ptr]   <= in_dont_care;
      mem_meta[wr_ptr] <= in_meta;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at DEPTH so any depth works, not only powers of two
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

endmodule : flit_push_fifo

`default_nettype wire

// File: logic/flit_serializer.sv
// Wide-to-narrow serializer that muxes one slice of the head flit per transfer
`default_nettype none

module flit_serializer #(
  // 1 sends the most significant slice first, 0 the least significant
  parameter bit MSB_FIRST = ser_cfg_pkg::DEFAULT_MSB_FIRST
) (
  input  wire                         clk,
  input  wire                         rst_n,
  // Head flit from the input FIFO, held stable until head_ready
  input  wire                         head_valid,
  output logic                        head_ready,
  input  ser_types_pkg::wide_data_t   head_data,
  input  wire                         head_last,
  input  ser_types_pkg::slice_id_t    head_dont_care,
  input  ser_types_pkg::meta_t        head_meta,
  // Narrow flit stream towards the skid slice
  output logic                        ser_valid,
  input  wire                         ser_ready,
  output ser_types_pkg::narrow_data_t ser_data,
  output logic                        ser_last,
  output ser_types_pkg::meta_t        ser_meta
);

  import ser_cfg_pkg::*;
  import ser_types_pkg::*;

  // Index of the final slice of a full flit
  localparam slice_id_t LAST_SLICE = slice_id_t'(SER_RATIO - 1);

  slice_id_t count;
  slice_id_t slice_sel;
  slice_id_t count_plus_dc;
  logic      ser_xfer;
  logic      flit_done;

  // ------------------------------
  // Handshake
  // ------------------------------

  // Zero cut-through latency, so a valid head is a valid slice
  assign ser_valid = head_valid;
  assign ser_xfer  = ser_valid && ser_ready;

  // Don't-care slices sit at the tail of the order whichever end goes first,
  // so the remaining count plus the don't-care count reaching the last index
  // marks the final slice that has to be sent
  assign count_plus_dc = count + head_dont_care;
  assign ser_last      = head_last && (count_plus_dc == LAST_SLICE);

  // A non-last flit always runs through every slice
  assign flit_done = head_last ? ser_last : (count == LAST_SLICE);

  // Pop the head only together with its final slice
  assign head_ready = ser_ready && flit_done;

  // ------------------------------
  // Slice counter
  // ------------------------------

  // The FIFO keeps the head stable, so the counter simply follows the
  // transfers and returns to zero once the flit is finished
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (ser_xfer) begin
      if (flit_done) begin
        count <= '0;
      end else begin
        count <= count + slice_id_t'(1);
      end
    end
  end

  // ------------------------------
  // Slice mux
  // ------------------------------

  // Counter position is mapped to a physical slice index by the order setting
  assign slice_sel = MSB_FIRST ? (LAST_SLICE - count) : count;

  // A binary mux over the slices, no shifting of the payload
  always_comb begin
    ser_data = '0;
    for (int i = 0; i < SER_RATIO; i++) begin
      if (slice_sel == slice_id_t'(i)) begin
        ser_data = head_data[i*POP_WIDTH +: POP_WIDTH];
      end
    end
  end

  // Metadata is replicated on every slice of the same wide flit
  assign ser_meta = head_meta;

endmodule : flit_serializer

`default_nettype wire

// File: logic/pop_skid_slice.sv
// Two-entry output register slice giving registered outputs and ready at full rate
`default_nettype none

module pop_skid_slice (
  input  wire                         clk,
  input  wire                         rst_n,
  // Narrow stream from the serializer
  input  wire                         ser_valid,
  output logic                        ser_ready,
  input  ser_types_pkg::narrow_data_t ser_data,
  input  wire                         ser_last,
  input  ser_types_pkg::meta_t        ser_meta,
  // Registered narrow stream leaving the block
  output logic                        out_valid,
  input  wire                         out_ready,
  output ser_types_pkg::narrow_data_t out_data,
  output logic                        out_last,
  output ser_types_pkg::meta_t        out_meta
);

  import ser_types_pkg::*;

  skid_state_t  state;
  skid_state_t  state_next;
  // Main register drives the outputs, skid register catches the overflow
  narrow_data_t main_data;
  logic         main_last;
  meta_t        main_meta;
  narrow_data_t skid_data;
  logic         skid_last;
  meta_t        skid_meta;
  logic         push;
  logic         pop;

  assign push      = ser_valid && ser_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (state != SKID_EMPTY);
  assign out_data  = main_data;
  assign out_last  = main_last;
  assign out_meta  = main_meta;

  // ------------------------------
  // Occupancy FSM
  // ------------------------------
  always_comb begin
    state_next = state;
    case (state)
      SKID_EMPTY: if (push) state_next = SKID_ONE;
      // Push and pop together keep one entry and sustain a flit per cycle
      SKID_ONE:   if (push && !pop) state_next = SKID_TWO;
                  else if (!push && pop) state_next = SKID_EMPTY;
      SKID_TWO:   if (pop) state_next = SKID_ONE;
      default:    state_next = SKID_EMPTY;
    endcase
  end

  // Ready comes from a flop, one entry of slack covers the cycle of delay
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= SKID_EMPTY;
      ser_ready <= 1'b1;
    end else begin
      state     <= state_next;
      ser_ready <= (state_next != SKID_TWO);
    end
  end

  // ------------------------------
  // Payload registers
  // ------------------------------
  always_ff @(posedge clk) begin
    // New data goes to main unless main is stalled with its flit still pending
    if (push && (state == SKID_EMPTY || pop)) begin
      main_data <= ser_data;
      main_last <= ser_last;
      main_meta <= ser_meta;
    end else if (push) begin
      skid_data <= ser_data;
      skid_last <= ser_last;
      skid_meta <= ser_meta;
    end else if (pop && state == SKID_TWO) begin
      // Refill main from the skid entry as the output drains
      main_data <= skid_data;
      main_last <= skid_last;
      main_meta <= skid_meta;
    end
  end

endmodule : pop_skid_slice

`default_nettype wire

// File: logic/ser_cfg_pkg.sv
// Serializer link configuration: bus widths, slice ratio and parameter defaults
`default_nettype none

package ser_cfg_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------

  // Width of one wide flit on the push side
  parameter int PUSH_WIDTH = 32;
  // Width of one narrow flit on the pop side
  parameter int POP_WIDTH = 8;
  // Sideband metadata carried unchanged next to every flit
  parameter int META_WIDTH = 3;

  // Number of narrow slices in one wide flit
  parameter int SER_RATIO = PUSH_WIDTH / POP_WIDTH;
  // Enough bits to index a slice or hold a don't-care count
  parameter int SLICE_ID_WIDTH = $clog2(SER_RATIO);

  // Default module parameters, overridden from the top level
  parameter bit DEFAULT_MSB_FIRST = 1'b1;
  parameter int DEFAULT_FIFO_DEPTH = 4;

endpackage : ser_cfg_pkg

`default_nettype wire

// File: logic/ser_types_pkg.sv
// Serializer data types: flit field vectors and the skid slice occupancy states
`default_nettype none

package ser_types_pkg;

  // ------------------------------
  // Flit fields
  // ------------------------------

  // Payload of one wide flit as accepted on the input side
  typedef logic [ser_cfg_pkg::PUSH_WIDTH-1:0] wide_data_t;

  // Payload of one narrow flit as presented on the output side
  typedef logic [ser_cfg_pkg::POP_WIDTH-1:0] narrow_data_t;

  // Metadata sideband, never serialized, only replicated
  typedef logic [ser_cfg_pkg::META_WIDTH-1:0] meta_t;

  // Slice index, also used for the don't-care count of a last flit
  typedef logic [ser_cfg_pkg::SLICE_ID_WIDTH-1:0] slice_id_t;

  // ------------------------------
  // Skid slice occupancy
  // ------------------------------

  // How many entries the output register slice currently holds
  typedef enum logic [1:0] {
    SKID_EMPTY = 2'd0,
    SKID_ONE   = 2'd1,
    SKID_TWO   = 2'd2
  } skid_state_t;

endpackage : ser_types_pkg

`default_nettype wire

// File: project.f
logic/ser_cfg_pkg.sv
logic/ser_types_pkg.sv
logic/flit_push_fifo.sv
logic/flit_serializer.sv
logic/pop_skid_slice.sv
logic/flit_narrow_top.sv
sim/serializer_checker.sv
sim/tb_flit_narrow.sv

// File: sim/serializer_checker.sv
// Protocol checker bound to the flit narrowing top level for reset and stall rules
`default_nettype none

module serializer_checker (
  input wire                         clk,
  input wire                         rst_n,
  input wire                         in_ready,
  input wire                         out_valid,
  input wire                         out_ready,
  input ser_types_pkg::narrow_data_t out_data,
  input wire                         out_last,
  input ser_types_pkg::meta_t        out_meta
);
  timeunit 1ns;
  timeprecision 1ps;

  // High from the second reset cycle on, when the synchronous reset has taken effect
  logic rst_seen = 1'b0;

  always @(posedge clk) begin
    rst_seen <= !rst_n;
  end

  // ------------------------------
  // Output stall rules
  // ------------------------------

  // A stalled narrow flit stays offered until it is taken
  out_hold_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> out_valid)
    else $error("out_valid dropped while the flit was stalled");

  // Payload, last flag and metadata do not move during a stall
  out_hold_fields: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_last) && $stable(out_meta)))
    else $error("out fields changed while the flit was stalled");

  // ------------------------------
  // Reset rules
  // ------------------------------

  // Held reset leaves the FIFO open and the output idle
  reset_state: assert property (@(posedge clk)
    (!rst_n && rst_seen) |-> (in_ready && !out_valid))
    else $error("in_ready low or out_valid high during reset");

endmodule : serializer_checker

bind flit_narrow_top serializer_checker u_checker (
  .clk          (clk),
  .rst_n        (rst_n),
  .in_ready     (in_ready),
  .out_valid    (out_valid),
  .out_ready    (out_ready),
  .out_data     (out_data),
  .out_last     (out_last),
  .out_meta     (out_meta)
);

`default_nettype wire

// File: sim/tb_flit_narrow.sv
// Testbench for the flit narrowing top level with LFSR stimulus and a slice reference queue
`default_nettype none

module tb_flit_narrow;
  timeunit 1ns;
  timeprecision 1ps;

  import ser_cfg_pkg::*;
  import ser_types_pkg::*;

  // Wide flits offered by each stream test
  localparam int FULL_FLITS = 8;
  localparam int LAST_FLITS = 8;
  localparam int META_FLITS = 16;
  localparam int BP_FLITS   = 40;
  localparam int THRU_FLITS = 16;
  localparam int MAX_SLICES =
    SER_RATIO * (FULL_FLITS + LAST_FLITS + META_FLITS + BP_FLITS + THRU_FLITS);
  localparam int TIMEOUT_CYCLES = 4 * MAX_SLICES + 200;

  logic         clk;
  logic         rst_n;
  logic         in_valid;
  logic         in_ready;
  wide_data_t   in_data;
  logic         in_last;
  slice_id_t    in_dont_care;
  meta_t        in_meta;
  logic         out_valid;
  logic         out_ready;
  narrow_data_t out_data;
  logic         out_last;
  meta_t        out_meta;

  // Narrow flits the DUT still owes, oldest first
  narrow_data_t exp_data [$];
  logic         exp_last [$];
  meta_t        exp_meta [$];

  logic [31:0] lfsr_state;
  int          errors;
  int          out_count;
  int          exp_count;
  int          cycle_count;
  int          tests_run;
  logic        thru_active;
  logic        thru_started;

  flit_narrow_top #(
    .MSB_FIRST  (1'b1),
    .FIFO_DEPTH (DEFAULT_FIFO_DEPTH)
  ) DUT (
    .clk, .rst_n,
    .in_valid, .in_ready, .in_data, .in_last, .in_dont_care, .in_meta,
    .out_valid, .out_ready, .out_data, .out_last, .out_meta
  );

  always #5 clk = ~clk;

  // ------------------------------
  // Random bits and reference model
  // ------------------------------

  // One step of a 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Gathers n fresh bits with one LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // A last flit drops its don't-care slices from the tail, the rest go out MSB first
  task automatic queue_expected(input wide_data_t d, input logic l, input slice_id_t dc,
                                input meta_t m);
    int n;
    int idx;
    n = l ? SER_RATIO - int'(dc) : SER_RATIO;
    for (int k = 0; k < n; k++) begin
      idx = SER_RATIO - 1 - k;
      exp_data.push_back(d[idx*POP_WIDTH +: POP_WIDTH]);
      exp_last.push_back(l && (k == n - 1));
      exp_meta.push_back(m);
    end
    exp_count += n;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, want);
      errors++;
    end
  endtask

  // ------------------------------
  // Monitor and timeout
  // ------------------------------
  always @(posedge clk) begin
    if (rst_n) begin
      // Once a back-to-back stream has started, every owed flit must be on offer
      if (thru_active && thru_started && exp_data.size() > 0) begin
        assert (out_valid) else begin
          $display("Output bubble with %0d narrow flits still owed", exp_data.size());
          errors++;
        end
      end
      if (out_valid && out_ready) begin
        out_count++;
        if (thru_active) begin
          thru_started = 1'b1;
        end
        assert (exp_data.size() > 0) else begin
          $display("Narrow flit left the DUT while nothing was owed");
          errors++;
        end
        if (exp_data.size() > 0) begin
          check_value("out_data", out_data, exp_data.pop_front());
          check_value("out_last", out_last, exp_last.pop_front());
          check_value("out_meta", out_meta, exp_meta.pop_front());
        end
      end
      if (in_valid && in_ready) begin
        queue_expected(in_data, in_last, in_dont_care, in_meta);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d narrow flits owed", cycle_count,
               exp_data.size());
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------

  // Mode 0 sends full flits, 1 last flits with every don't-care count, 2 a random mix.
  // Inputs change only on the falling edge, and in_ready is read there because it
  // only moves on a rising edge
  task automatic run_stream(input int n, input int mode, input bit gaps,
                            input bit rand_ready, input bit meta_walk);
    int sent;
    int gap;
    bit will_take;
    sent = 0;
    gap  = 0;
    while (sent < n) begin
      out_ready = rand_ready ? (take_bits(1) != 0) : 1'b1;
      if (!in_valid && gap == 0) begin
        in_data = take_bits(PUSH_WIDTH);
        in_meta = meta_walk ? meta_t'(sent) : meta_t'(take_bits(META_WIDTH));
        in_last = (mode == 1);
        if (mode == 2) begin
          in_last = (take_bits(1) != 0);
        end
        in_dont_care = (mode == 1) ? slice_id_t'(sent) : slice_id_t'(take_bits(SLICE_ID_WIDTH));
        in_valid = 1'b1;
      end else if (!in_valid) begin
        gap--;
      end
      will_take = in_valid && in_ready;
      @(negedge clk);
      if (will_take) begin
        sent++;
        in_valid = 1'b0;
        gap = gaps ? int'(take_bits(2)) : 0;
      end
    end
    // Drain under the same ready policy until every owed flit is out
    while (exp_data.size() != 0) begin
      out_ready = rand_ready ? (take_bits(1) != 0) : 1'b1;
      @(negedge clk);
    end
    out_ready = 1'b1;
    @(negedge clk);
    check_value("out_valid", out_valid, 32'h0);
  endtask

  task automatic run_test(input string name, input int n, input int mode, input bit gaps,
                          input bit rand_ready, input bit meta_walk, input bit bubbles);
    int err0;
    int out0;
    int exp0;
    err0 = errors;
    out0 = out_count;
    exp0 = exp_count;
    thru_started = 1'b0;
    thru_active  = bubbles;
    run_stream(n, mode, gaps, rand_ready, meta_walk);
    thru_active = 1'b0;
    assert (out_count - out0 == exp_count - exp0) else begin
      $display("%s sent %0d narrow flits but %0d were owed", name, out_count - out0,
               exp_count - exp0);
      errors++;
    end
    tests_run++;
    $display("%-13s %0d wide, %0d narrow, %0d errors", name, n, out_count - out0,
             errors - err0);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_data      = '0;
    in_last      = 1'b0;
    in_dont_care = '0;
    in_meta      = '0;
    out_ready    = 1'b0;
    lfsr_state   = 32'd74731;
    errors       = 0;
    out_count    = 0;
    exp_count    = 0;
    tests_run    = 0;
    thru_active  = 1'b0;
    thru_started = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // An idle DUT out of reset accepts input and sends nothing
    check_value("in_ready", in_ready, 32'h1);
    check_value("out_valid", out_valid, 32'h0);
    out_ready = 1'b1;
    repeat (20) @(negedge clk);
    check_value("out_count", out_count, 32'h0);
    tests_run++;
    $display("%-13s 0 wide, %0d narrow, %0d errors", "reset", out_count, errors);

    run_test("full_flits", FULL_FLITS, 0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("last_flits", LAST_FLITS, 1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("metadata", META_FLITS, 2, 1'b1, 1'b0, 1'b1, 1'b0);
    run_test("back_pressure", BP_FLITS, 2, 1'b1, 1'b1, 1'b0, 1'b0);
    run_test("throughput", THRU_FLITS, 2, 1'b0, 1'b0, 1'b0, 1'b1);

    $display("tests %0d, narrow flits checked %0d, errors %0d", tests_run, out_count, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_flit_narrow

`default_nettype wire
